// ==== verilog/pcd_tx_pkg.sv ====
// ----------------------------------------
// Miller sequence and slot symbol types,
// ISO 14443A default timing, shifter load
// selects and the CRC_A byte update
// ----------------------------------------

package pcd_tx_pkg;

    // the three modified Miller sequences
    typedef enum logic [1:0] {
        SEQ_X,
        SEQ_Y,
        SEQ_Z
    } pcd_seq_t;

    // what a bit slot carries on the air
    typedef enum logic [1:0] {
        SYM_SOF,
        SYM_DATA,
        SYM_EOF_ZERO,
        SYM_EOF_Y
    } pcd_sym_t;

    // carrier ticks per bit time and pause timing (ISO/IEC 14443-2)
    localparam int DEF_BIT_TICKS   = 128;
    localparam int DEF_PAUSE_TICKS = 32;
    localparam int DEF_X_OFFSET    = 64;
    localparam int DEF_Z_OFFSET    = 0;

    localparam logic [15:0] CRC_A_INIT = 16'h6363;

    // byte source for the shifter on a load
    localparam logic [1:0] LOAD_DATA   = 2'd0;
    localparam logic [1:0] LOAD_CRC_LO = 2'd1;
    localparam logic [1:0] LOAD_CRC_HI = 2'd2;

    // byte-wise CRC_A step, the data byte is folded into the low CRC byte first
    function automatic logic [15:0] crc_a_update(input logic [15:0] crc, input logic [7:0] data);
        logic [7:0] t;
        t = data ^ crc[7:0];
        t = t ^ {t[3:0], 4'd0};
        return {8'd0, crc[15:8]} ^ {t, 8'd0} ^ {5'd0, t, 3'd0} ^ {12'd0, t[7:4]};
    endfunction

endpackage

// ==== verilog/pcd_slot_if.sv ====
// ----------------------------------------
// bit slot timing and current symbol
// ----------------------------------------

`timescale 1ns/10ps

// every signal here lives in the pcd_clk domain
interface pcd_slot_if
    import pcd_tx_pkg::*;
#(
    parameter int BIT_TICKS = DEF_BIT_TICKS
);

    logic                         run;
    logic                         bit_start;
    logic [$clog2(BIT_TICKS)-1:0] tick_count;
    pcd_sym_t                     symbol;
    logic                         bit_value;

    modport etu (input run, output bit_start, output tick_count);

    // the sequencer watches tick_count to find the last tick of the frame
    modport sequencer (output run, output symbol, output bit_value,
                       input bit_start, input tick_count);

    modport encoder (input run, input bit_start, input tick_count,
                     input symbol, input bit_value);

endinterface

// ==== verilog/pcd_etu_counter.sv ====
// ----------------------------------------
// carrier tick counter for one bit time
// ----------------------------------------

`timescale 1ns/10ps

module pcd_etu_counter
    import pcd_tx_pkg::*;
#(
    parameter int BIT_TICKS = DEF_BIT_TICKS
) (
    input  logic   pcd_clk,
    input  logic   reset,
    pcd_slot_if.etu slot
);

    // the count sits at 0 while idle, so the first run cycle is tick 0 of the SOF slot
    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            slot.tick_count <= '0;
        end
        else if (!slot.run) begin
            slot.tick_count <= '0;
        end
        else if (int'(slot.tick_count) == BIT_TICKS - 1) begin
            slot.tick_count <= '0;
        end
        else begin
            slot.tick_count <= slot.tick_count + 1'b1;
        end
    end

    // one pulse on tick 0 of every slot
    assign slot.bit_start = slot.run && (slot.tick_count == '0);

endmodule

// ==== verilog/pcd_frame_sequencer.sv ====
// ----------------------------------------
// frame FSM, SOF, data bits with parity,
// CRC bytes and EOF
// ----------------------------------------

`timescale 1ns/10ps

module pcd_frame_sequencer
    import pcd_tx_pkg::*;
#(
    parameter int BIT_TICKS = DEF_BIT_TICKS
) (
    input  logic          pcd_clk,
    input  logic          reset,
    input  logic          start,
    input  logic          tx_last,
    input  logic          add_crc,
    output logic          data_req,
    output logic          sending,
    output logic [1:0]    load_sel,
    output logic          load,
    output logic          shift,
    input  logic          shift_bit,
    input  logic          parity,
    output logic          crc_clear,
    output logic          crc_update,
    pcd_slot_if.sequencer slot
);

    typedef enum logic [2:0] {IDLE, SOF, DATA, PARITY, CRC_BYTES, EOF_ZERO, EOF_Y} state_t;

    state_t     state_q, state_d;
    logic [3:0] idx_q, idx_d;
    logic       crc_hi_q, crc_hi_d;
    pcd_sym_t   sym_q, sym_d;
    logic       bit_q, bit_d;
    logic       active;
    logic       crc_en_q;
    logic       last_q;
    logic       start_ok;
    logic       slot_end;

    assign start_ok = start && !active;
    assign slot_end = int'(slot.tick_count) == BIT_TICKS - 1;

    // ----------------------------------------
    // next slot decision
    // ----------------------------------------

    // the state names the slot on air, it moves on at the bit_start of the following slot
    always_comb begin
        state_d  = state_q;
        idx_d    = idx_q;
        crc_hi_d = crc_hi_q;
        sym_d    = sym_q;
        bit_d    = bit_q;
        load     = 1'b0;
        load_sel = LOAD_DATA;
        shift    = 1'b0;
        data_req = 1'b0;
        if (start_ok) begin
            // byte 0 goes into the shifter straight away
            state_d = IDLE;
            load    = 1'b1;
        end
        else if (slot.bit_start) begin
            sym_d = SYM_DATA;
            bit_d = shift_bit;
            case (state_q)
                IDLE: begin
                    state_d = SOF;
                    sym_d   = SYM_SOF;
                    bit_d   = 1'b0;
                end
                SOF: begin
                    state_d = DATA;
                    idx_d   = 4'd0;
                    shift   = 1'b1;
                end
                DATA: begin
                    if (idx_q == 4'd7) begin
                        state_d = PARITY;
                        bit_d   = parity;
                    end
                    else begin
                        idx_d = idx_q + 4'd1;
                        shift = 1'b1;
                    end
                end
                PARITY: begin
                    idx_d = 4'd0;
                    if (!last_q) begin
                        // next data byte is loaded and its bit 0 sent in the same slot
                        state_d  = DATA;
                        load     = 1'b1;
                        shift    = 1'b1;
                        data_req = 1'b1;
                    end
                    else if (crc_en_q) begin
                        state_d  = CRC_BYTES;
                        crc_hi_d = 1'b0;
                        load     = 1'b1;
                        load_sel = LOAD_CRC_LO;
                        shift    = 1'b1;
                    end
                    else begin
                        state_d = EOF_ZERO;
                        sym_d   = SYM_EOF_ZERO;
                        bit_d   = 1'b0;
                    end
                end
                CRC_BYTES: begin
                    // index 8 is the parity slot of the CRC byte
                    if (idx_q == 4'd8 && !crc_hi_q) begin
                        idx_d    = 4'd0;
                        crc_hi_d = 1'b1;
                        load     = 1'b1;
                        load_sel = LOAD_CRC_HI;
                        shift    = 1'b1;
                    end
                    else if (idx_q == 4'd8) begin
                        state_d = EOF_ZERO;
                        sym_d   = SYM_EOF_ZERO;
                        bit_d   = 1'b0;
                    end
                    else if (idx_q == 4'd7) begin
                        idx_d = 4'd8;
                        bit_d = parity;
                    end
                    else begin
                        idx_d = idx_q + 4'd1;
                        shift = 1'b1;
                    end
                end
                EOF_ZERO: begin
                    state_d = EOF_Y;
                    sym_d   = SYM_EOF_Y;
                    bit_d   = 1'b0;
                end
                default: begin
                    state_d = state_q;
                    sym_d   = sym_q;
                    bit_d   = bit_q;
                end
            endcase
        end
    end

    // ----------------------------------------
    // state registers
    // ----------------------------------------

    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            active   <= 1'b0;
            state_q  <= IDLE;
            idx_q    <= 4'd0;
            crc_hi_q <= 1'b0;
            sym_q    <= SYM_SOF;
            bit_q    <= 1'b0;
            crc_en_q <= 1'b0;
            last_q   <= 1'b0;
        end
        else begin
            state_q  <= state_d;
            idx_q    <= idx_d;
            crc_hi_q <= crc_hi_d;
            sym_q    <= sym_d;
            bit_q    <= bit_d;
            if (start_ok) begin
                active   <= 1'b1;
                crc_en_q <= add_crc;
            end
            else if (state_q == EOF_Y && slot_end) begin
                // the frame ends with the last tick of the EOF Y slot
                active <= 1'b0;
            end
            if (start_ok || data_req) begin
                last_q <= tx_last;
            end
        end
    end

    // the symbol is already valid on tick 0, the encoder samples it there
    assign slot.symbol    = slot.bit_start ? sym_d : sym_q;
    assign slot.bit_value = slot.bit_start ? bit_d : bit_q;
    assign slot.run       = active;
    assign sending        = active;

    // the CRC covers data bytes only
    assign crc_clear  = start_ok;
    assign crc_update = load && (load_sel == LOAD_DATA);

endmodule

// ==== verilog/pcd_byte_shifter.sv ====
// ----------------------------------------
// byte shift register, LSB first, with
// running odd parity
// ----------------------------------------

`timescale 1ns/10ps

module pcd_byte_shifter
    import pcd_tx_pkg::*;
(
    input  logic        pcd_clk,
    input  logic        reset,
    input  logic        load,
    input  logic [1:0]  load_sel,
    input  logic [7:0]  tx_data,
    input  logic [15:0] crc,
    input  logic        shift,
    output logic        shift_bit,
    output logic        parity
);

    logic [7:0] sr;
    logic [7:0] sel_byte;
    logic [7:0] cur_byte;

    always_comb begin
        case (load_sel)
            LOAD_CRC_LO: sel_byte = crc[7:0];
            LOAD_CRC_HI: sel_byte = crc[15:8];
            default:     sel_byte = tx_data;
        endcase
    end

    // a load together with a shift sends bit 0 of the new byte in that same cycle
    assign cur_byte  = load ? sel_byte : sr;
    assign shift_bit = cur_byte[0];

    // parity starts at 1 and flips on every 1 shifted out, giving odd parity
    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            sr     <= 8'd0;
            parity <= 1'b1;
        end
        else if (load || shift) begin
            sr     <= shift ? {1'b0, cur_byte[7:1]} : cur_byte;
            parity <= (load ? 1'b1 : parity) ^ (shift & cur_byte[0]);
        end
    end

endmodule

// ==== verilog/pcd_crc_a.sv ====
// ----------------------------------------
// CRC_A accumulator over frame data bytes
// ----------------------------------------

`timescale 1ns/10ps

module pcd_crc_a
    import pcd_tx_pkg::*;
(
    input  logic        pcd_clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        update,
    input  logic [7:0]  data,
    output logic [15:0] crc
);

    logic [7:0] data_q;
    logic       pend;

    // the byte is captured with its load and folded in on the next cycle
    always_ff @(posedge pcd_clk) begin
        if (update) begin
            data_q <= data;
        end
    end

    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            pend <= 1'b0;
            crc  <= CRC_A_INIT;
        end
        else begin
            pend <= update;
            if (clear) begin
                crc <= CRC_A_INIT;
            end
            else if (pend) begin
                crc <= crc_a_update(crc, data_q);
            end
        end
    end

endmodule

// ==== verilog/pcd_miller_encoder.sv ====
// ----------------------------------------
// modified Miller encoder driving pause_n
// ----------------------------------------

`timescale 1ns/10ps

module pcd_miller_encoder
    import pcd_tx_pkg::*;
#(
    parameter int PAUSE_TICKS = DEF_PAUSE_TICKS,
    parameter int X_OFFSET    = DEF_X_OFFSET,
    parameter int Z_OFFSET    = DEF_Z_OFFSET
) (
    input  logic        pcd_clk,
    input  logic        reset,
    pcd_slot_if.encoder slot,
    output logic        pause_n
);

    pcd_seq_t seq_q;
    pcd_seq_t seq_d;
    pcd_seq_t cur_seq;
    int       tick;
    logic     in_pause;

    // a 1 is X, a 0 after X is Y and any other 0 is Z
    always_comb begin
        case (slot.symbol)
            SYM_SOF:   seq_d = SEQ_Z;
            SYM_EOF_Y: seq_d = SEQ_Y;
            default: begin
                if (slot.symbol == SYM_DATA && slot.bit_value) begin
                    seq_d = SEQ_X;
                end
                else begin
                    seq_d = (seq_q == SEQ_X) ? SEQ_Y : SEQ_Z;
                end
            end
        endcase
    end

    // the new sequence is needed on tick 0 already for Z
    always_comb begin
        cur_seq = slot.bit_start ? seq_d : seq_q;
        tick    = int'(slot.tick_count);
        case (cur_seq)
            SEQ_X:   in_pause = (tick >= X_OFFSET) && (tick < X_OFFSET + PAUSE_TICKS);
            SEQ_Z:   in_pause = (tick >= Z_OFFSET) && (tick < Z_OFFSET + PAUSE_TICKS);
            default: in_pause = 1'b0;
        endcase
    end

    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            seq_q   <= SEQ_Y;
            pause_n <= 1'b1;
        end
        else begin
            if (slot.bit_start) begin
                seq_q <= seq_d;
            end
            pause_n <= !(slot.run && in_pause);
        end
    end

endmodule

// ==== verilog/iso14443a_pcd_tx.sv ====
// ----------------------------------------
// ISO 14443A PCD to PICC transmitter top
// ----------------------------------------

`timescale 1ns/10ps

module iso14443a_pcd_tx
    import pcd_tx_pkg::*;
#(
    parameter int BIT_TICKS   = DEF_BIT_TICKS,
    parameter int PAUSE_TICKS = DEF_PAUSE_TICKS,
    parameter int X_OFFSET    = DEF_X_OFFSET,
    parameter int Z_OFFSET    = DEF_Z_OFFSET
) (
    input  logic       pcd_clk,
    input  logic       reset,
    input  logic       start,
    input  logic [7:0] tx_data,
    input  logic       tx_last,
    input  logic       add_crc,
    output logic       data_req,
    output logic       sending,
    output logic       pause_n
);

    logic [1:0]  load_sel;
    logic        load;
    logic        shift;
    logic        shift_bit;
    logic        parity;
    logic        crc_clear;
    logic        crc_update;
    logic [15:0] crc;

    pcd_slot_if #(.BIT_TICKS(BIT_TICKS)) slot_if ();

    pcd_etu_counter #(.BIT_TICKS(BIT_TICKS)) etu0 (
        .pcd_clk (pcd_clk),
        .reset   (reset),
        .slot    (slot_if.etu)
    );

    pcd_frame_sequencer #(.BIT_TICKS(BIT_TICKS)) seq0 (
        .pcd_clk    (pcd_clk),
        .reset      (reset),
        .start      (start),
        .tx_last    (tx_last),
        .add_crc    (add_crc),
        .data_req   (data_req),
        .sending    (sending),
        .load_sel   (load_sel),
        .load       (load),
        .shift      (shift),
        .shift_bit  (shift_bit),
        .parity     (parity),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .slot       (slot_if.sequencer)
    );

    pcd_byte_shifter shift0 (
        .pcd_clk   (pcd_clk),
        .reset     (reset),
        .load      (load),
        .load_sel  (load_sel),
        .tx_data   (tx_data),
        .crc       (crc),
        .shift     (shift),
        .shift_bit (shift_bit),
        .parity    (parity)
    );

    pcd_crc_a crc0 (
        .pcd_clk (pcd_clk),
        .reset   (reset),
        .clear   (crc_clear),
        .update  (crc_update),
        .data    (tx_data),
        .crc     (crc)
    );

    pcd_miller_encoder #(
        .PAUSE_TICKS (PAUSE_TICKS),
        .X_OFFSET    (X_OFFSET),
        .Z_OFFSET    (Z_OFFSET)
    ) enc0 (
        .pcd_clk (pcd_clk),
        .reset   (reset),
        .slot    (slot_if.encoder),
        .pause_n (pause_n)
    );

endmodule

// ==== bench/iso14443a_pcd_tx_asserts.sv ====
// ----------------------------------------
// concurrent checks on pause_n, sending
// and data_req of the transmitter top
// ----------------------------------------

`timescale 1ns/10ps

module iso14443a_pcd_tx_asserts
    import pcd_tx_pkg::*;
#(
    parameter int PAUSE_TICKS = DEF_PAUSE_TICKS
) (
    input logic pcd_clk,
    input logic reset,
    input logic sending,
    input logic data_req,
    input logic pause_n
);

    // length of the pause in progress or 0 while the carrier is on
    int low_cnt;
    // number of failed assertions so far
    int fail_count = 0;

    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            low_cnt <= 0;
        end
        else if (!pause_n) begin
            low_cnt <= low_cnt + 1;
        end
        else begin
            low_cnt <= 0;
        end
    end

    idle_no_pause: assert property (@(posedge pcd_clk) disable iff (reset) !sending |-> pause_n)
        else begin
            fail_count++;
            $error("pause_n low while not sending");
        end

    req_in_frame: assert property (@(posedge pcd_clk) disable iff (reset) data_req |-> sending)
        else begin
            fail_count++;
            $error("data_req outside a frame");
        end

    req_one_cycle: assert property (@(posedge pcd_clk) disable iff (reset) data_req |=> !data_req)
        else begin
            fail_count++;
            $error("data_req longer than one cycle");
        end

    // a pause may not outgrow its length, and the first high cycle sees the full count
    pause_not_long: assert property (@(posedge pcd_clk) disable iff (reset)
        !pause_n |-> (low_cnt < PAUSE_TICKS))
        else begin
            fail_count++;
            $error("pause longer than PAUSE_TICKS");
        end

    pause_exact: assert property (@(posedge pcd_clk) disable iff (reset)
        (pause_n && low_cnt != 0) |-> (low_cnt == PAUSE_TICKS))
        else begin
            fail_count++;
            $error("pause shorter than PAUSE_TICKS");
        end

endmodule

bind iso14443a_pcd_tx iso14443a_pcd_tx_asserts #(.PAUSE_TICKS(PAUSE_TICKS)) asserts0 (.*);

// ==== bench/iso14443a_pcd_tx_tb.sv ====
// ----------------------------------------
// table-driven testbench for the PCD
// transmitter, pause_n decoder, CRC_A
// reference model and frame checks
// ----------------------------------------

`timescale 1ns/10ps

module iso14443a_pcd_tx_tb
    import pcd_tx_pkg::*;
();

    localparam int BIT_TICKS   = DEF_BIT_TICKS;
    localparam int PAUSE_TICKS = DEF_PAUSE_TICKS;
    localparam int X_OFFSET    = DEF_X_OFFSET;
    localparam int Z_OFFSET    = DEF_Z_OFFSET;
    localparam int NUM_TESTS   = 7;
    localparam int MAX_SLOTS   = 128;
    // a stray start lands in the middle of slot 5
    localparam int MID_CYCLE   = 5 * BIT_TICKS + 7;

    // one table row per frame with byte 0 in the low bits of the fixed bytes
    typedef struct packed {
        logic [3:0]  nbytes;
        logic        crc;
        logic        rnd;
        logic        mid_start;
        logic [31:0] bytes;
        logic [15:0] known_crc;
    } row_t;

    logic        pcd_clk;
    logic        reset;
    logic        start;
    logic [7:0]  tx_data;
    logic        tx_last;
    logic        add_crc;
    logic        data_req;
    logic        sending;
    logic        pause_n;

    row_t        table_q [NUM_TESTS];
    // data bytes followed by the expected CRC bytes
    logic [7:0]  frame_b [16];
    // decoded sequence per slot that stays Y where no pause was seen
    pcd_seq_t    obs [MAX_SLOTS];
    logic [31:0] rng;
    int          errors;
    int          test_errors;
    int          passed;
    int          t;
    int          assert_seen;
    bit          aborted;

    iso14443a_pcd_tx #(
        .BIT_TICKS   (BIT_TICKS),
        .PAUSE_TICKS (PAUSE_TICKS),
        .X_OFFSET    (X_OFFSET),
        .Z_OFFSET    (Z_OFFSET)
    ) dut0 (
        .pcd_clk  (pcd_clk),
        .reset    (reset),
        .start    (start),
        .tx_data  (tx_data),
        .tx_last  (tx_last),
        .add_crc  (add_crc),
        .data_req (data_req),
        .sending  (sending),
        .pause_n  (pause_n)
    );

    initial begin
        pcd_clk = 1'b0;
        forever #50 pcd_clk = ~pcd_clk;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // CRC_A from its definition as the reflected CCITT polynomial taken one bit at a time
    function automatic logic [15:0] crc_a_bitwise(input logic [15:0] crc, input logic [7:0] data);
        logic [15:0] c;
        int          i;
        c = crc ^ {8'd0, data};
        for (i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
        end
        return c;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // assertion failures since the last call count as errors of the current test
    task automatic collect_assert_fails();
        int delta;
        delta       = dut0.asserts0.fail_count - assert_seen;
        assert_seen = dut0.asserts0.fail_count;
        errors      += delta;
        test_errors += delta;
    endtask

    // bytes past the end of the frame are driven as zero with tx_last high
    task automatic drive_byte(input int idx, input int n);
        tx_data = (idx < n) ? frame_b[idx] : 8'h00;
        tx_last = (idx >= n - 1);
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (sending && cnt < 4 * BIT_TICKS) begin
            @(negedge pcd_clk);
            cnt++;
        end
        if (sending) begin
            $display("timeout: sending never went low before a new frame");
            aborted = 1'b1;
        end
    endtask

    task automatic load_table();
        table_q[0] = '{4'd1, 1'b0, 1'b0, 1'b0, 32'h0000_00B2, 16'h0000};
        table_q[1] = '{4'd2, 1'b1, 1'b0, 1'b0, 32'h0000_0000, 16'h1EA0};
        table_q[2] = '{4'd2, 1'b1, 1'b0, 1'b1, 32'h0000_3412, 16'hCF26};
        table_q[3] = '{4'd1, 1'b0, 1'b0, 1'b1, 32'h0000_0000, 16'h0000};
        table_q[4] = '{4'd3, 1'b1, 1'b0, 1'b0, 32'h00FF_7093, 16'h0000};
        table_q[5] = '{4'd4, 1'b0, 1'b1, 1'b0, 32'h0000_0000, 16'h0000};
        table_q[6] = '{4'd8, 1'b1, 1'b1, 1'b1, 32'h0000_0000, 16'h0000};
    endtask

    // ----------------------------------------
    // one frame driven and decoded per cycle
    // ----------------------------------------

    task automatic run_frame(input int idx);
        row_t        r;
        int          n;
        int          nb;
        int          c;
        int          limit;
        int          width;
        int          req_count;
        int          nxt;
        int          rise_wait;
        int          sl;
        int          tk;
        int          i;
        int          j;
        logic        pend;
        logic        prev_p;
        logic        bitv;
        logic        par;
        logic [15:0] crc_m;
        logic [7:0]  eb;
        logic [7:0]  db;
        pcd_seq_t    prev;
        pcd_seq_t    e;
        r = table_q[idx];
        n = int'(r.nbytes);
        test_errors = 0;
        for (i = 0; i < n; i++) begin
            if (r.rnd) begin
                rng = xorshift32(rng);
                frame_b[i] = rng[7:0];
            end
            else begin
                frame_b[i] = r.bytes[8*i +: 8];
            end
        end
        crc_m = 16'h6363;
        for (i = 0; i < n; i++) begin
            crc_m = crc_a_bitwise(crc_m, frame_b[i]);
        end
        if (r.known_crc != 16'h0000) begin
            check_eq(32'(crc_m), 32'(r.known_crc), "reference CRC_A");
        end
        // low CRC byte goes on air first
        frame_b[n]     = crc_m[7:0];
        frame_b[n + 1] = crc_m[15:8];
        nb = n + (r.crc ? 2 : 0);
        for (i = 0; i < MAX_SLOTS; i++) begin
            obs[i] = SEQ_Y;
        end

        wait_idle();
        if (aborted) begin
            return;
        end
        start   = 1'b1;
        add_crc = r.crc;
        drive_byte(0, n);
        @(negedge pcd_clk);
        start = 1'b0;
        rise_wait = 0;
        while (!sending && rise_wait < 8) begin
            @(negedge pcd_clk);
            rise_wait++;
        end
        if (!sending) begin
            $display("timeout: sending did not rise after start in test %0d", idx);
            aborted = 1'b1;
            return;
        end
        check_eq(rise_wait, 0, "extra cycles from start to sending");

        // sample c is cycle c of the frame and pause_n trails the slot tick by one
        nxt       = 1;
        drive_byte(nxt, n);
        c         = 0;
        width     = 0;
        req_count = 0;
        pend      = 1'b0;
        prev_p    = 1'b1;
        limit     = (5 + 9 * nb) * BIT_TICKS;
        while (sending && c < limit) begin
            // the byte is taken in the data_req cycle, so the next one follows a cycle later
            if (pend) begin
                nxt++;
                drive_byte(nxt, n);
                pend = 1'b0;
            end
            if (data_req) begin
                req_count++;
                pend = 1'b1;
            end
            start = r.mid_start && (c == MID_CYCLE);
            if (!pause_n) begin
                width++;
            end
            if (!pause_n && prev_p) begin
                sl = (c - 1) / BIT_TICKS;
                tk = (c - 1) % BIT_TICKS;
                if (c == 0 || sl >= MAX_SLOTS) begin
                    $display("pause at cycle %0d lies outside the frame slots", c);
                    errors++;
                    test_errors++;
                end
                else if (tk == X_OFFSET) begin
                    obs[sl] = SEQ_X;
                end
                else begin
                    check_eq(tk, Z_OFFSET, $sformatf("pause start tick in slot %0d", sl));
                    obs[sl] = SEQ_Z;
                end
            end
            if (pause_n && !prev_p) begin
                check_eq(width, PAUSE_TICKS, "pause width");
                width = 0;
            end
            prev_p = pause_n;
            c++;
            @(negedge pcd_clk);
        end
        start = 1'b0;
        if (sending) begin
            $display("timeout: sending stayed high past the frame in test %0d", idx);
            aborted = 1'b1;
            return;
        end
        check_eq(c, (3 + 9 * nb) * BIT_TICKS, "sending length in cycles");
        check_eq(req_count, n - 1, "data_req pulses");
        check_eq(pause_n, 1'b1, "pause_n after frame");

        // replay the Miller rule over the bit stream and decode the bytes back
        check_eq(32'(obs[0]), 32'(SEQ_Z), "SOF sequence");
        prev = SEQ_Z;
        for (i = 0; i < nb; i++) begin
            eb  = frame_b[i];
            db  = 8'd0;
            par = 1'b0;
            for (j = 0; j < 9; j++) begin
                bitv = (j < 8) ? eb[j] : ~^eb;
                e = bitv ? SEQ_X : ((prev == SEQ_X) ? SEQ_Y : SEQ_Z);
                check_eq(32'(obs[1 + 9*i + j]), 32'(e), $sformatf("byte %0d slot %0d", i, j));
                prev = e;
                if (j < 8) begin
                    db[j] = (obs[1 + 9*i + j] == SEQ_X);
                end
                else begin
                    par = (obs[1 + 9*i + j] == SEQ_X);
                end
            end
            check_eq(db, eb, $sformatf("decoded byte %0d", i));
            check_eq(^db ^ par, 1'b1, $sformatf("odd parity of byte %0d", i));
        end
        e = (prev == SEQ_X) ? SEQ_Y : SEQ_Z;
        check_eq(32'(obs[1 + 9*nb]), 32'(e), "EOF logic 0");
        check_eq(32'(obs[2 + 9*nb]), 32'(SEQ_Y), "EOF closing Y");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        tx_data     = 8'h00;
        tx_last     = 1'b0;
        add_crc     = 1'b0;
        errors      = 0;
        passed      = 0;
        assert_seen = 0;
        aborted     = 1'b0;
        rng         = 32'h8134;
        load_table();
        repeat (5) @(posedge pcd_clk);
        @(negedge pcd_clk);
        reset = 1'b0;
        @(negedge pcd_clk);
        check_eq({sending, data_req, pause_n}, 3'b001, "outputs after reset");
        for (t = 0; t < NUM_TESTS && !aborted; t++) begin
            run_frame(t);
            collect_assert_fails();
            if (!aborted) begin
                $display("test %0d: %0d bytes, add_crc %0d, %0d errors",
                         t, table_q[t].nbytes, table_q[t].crc, test_errors);
                if (test_errors == 0) begin
                    passed++;
                end
            end
            repeat (3) @(negedge pcd_clk);
        end
        collect_assert_fails();
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, passed, NUM_TESTS - passed, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== iso14443a_pcd_tx.f ====
verilog/pcd_tx_pkg.sv
verilog/pcd_slot_if.sv
verilog/pcd_etu_counter.sv
verilog/pcd_frame_sequencer.sv
verilog/pcd_byte_shifter.sv
verilog/pcd_crc_a.sv
verilog/pcd_miller_encoder.sv
verilog/iso14443a_pcd_tx.sv
bench/iso14443a_pcd_tx_asserts.sv
bench/iso14443a_pcd_tx_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = iso14443a_pcd_tx_tb
FILELIST   = iso14443a_pcd_tx.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
